//--- list.f
vseq_pkg.sv
vseq_sequencer.sv
vseq_lane.sv
vseq_mem_unit.sv
vseq_top.sv
tb_clkgen.sv
tb_vseq.sv

//--- Makefile
# Verilator flow for the vector sequencer testbench

TOP := tb_vseq

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# A $fatal in the testbench gives a nonzero exit status
sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- tb_vseq.sv
//****************************************
// Vector sequencer testbench
// Random requests checked against a hazard and slot model
//****************************************
`timescale 1ns/10ps

module tb_vseq import vseq_pkg::*; ();

  localparam int unsigned NR_REQS        = 300;
  localparam int unsigned TIMEOUT_CYCLES = NR_REQS * 80;

  logic clk, rst_n;

  // Dispatcher side
  logic                req_valid, req_ready;
  vseq_op_e            req_op;
  logic [VREG_W-1:0]   req_vs1, req_vs2, req_vd;
  logic                req_use_vs1, req_use_vs2, req_use_vd, req_vm;
  logic [VL_W-1:0]     req_vl;
  logic [SCALAR_W-1:0] req_scalar;
  logic                resp_valid, resp_error;
  logic [SCALAR_W-1:0] resp_data;
  logic [NR_VINSN-1:0] done;
  // Issue trace
  logic                issue_valid;
  logic [VID_W-1:0]    issue_id;
  logic [NR_VINSN-1:0] hz_vs1, hz_vs2, hz_vd, hz_vm;

  // Model state
  logic [31:0]         lfsr_q;
  logic [NR_VINSN-1:0] model_run, busy_now;
  logic [NR_VREGS-1:0] rd_vld, wr_vld;
  logic [VID_W-1:0]    rd_id [NR_VREGS];
  logic [VID_W-1:0]    wr_id [NR_VREGS];
  // Accepted request waiting for its issue pulse
  logic                pend_issue, taken;
  logic [NR_VINSN-1:0] pend_busy, exp_vs1, exp_vs2, exp_vd, exp_vm;
  // Outstanding response
  logic                wait_resp, wait_err;
  vseq_op_e            wait_op;
  logic [VL_W-1:0]     wait_vl;
  int unsigned         accepted, cycles;

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vseq_top UUT (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .req_valid_i        (req_valid),
    .req_op_i           (req_op),
    .req_vs1_i          (req_vs1),
    .req_use_vs1_i      (req_use_vs1),
    .req_vs2_i          (req_vs2),
    .req_use_vs2_i      (req_use_vs2),
    .req_vd_i           (req_vd),
    .req_use_vd_i       (req_use_vd),
    .req_vm_i           (req_vm),
    .req_vl_i           (req_vl),
    .req_scalar_i       (req_scalar),
    .req_ready_o        (req_ready),
    .resp_valid_o       (resp_valid),
    .resp_data_o        (resp_data),
    .resp_error_o       (resp_error),
    .done_o             (done),
    .issue_valid_o      (issue_valid),
    .issue_id_o         (issue_id),
    .issue_hazard_vs1_o (hz_vs1),
    .issue_hazard_vs2_o (hz_vs2),
    .issue_hazard_vd_o  (hz_vd),
    .issue_hazard_vm_o  (hz_vm)
  );

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Galois LFSR shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic new_request();
    logic [31:0] r;
    rand_bits(3, r);
    req_op = vseq_op_e'(r[2:0]);
    // Only eight registers so that accesses collide often
    rand_bits(3, r);
    req_vs1 = VREG_W'(r[2:0]);
    rand_bits(3, r);
    req_vs2 = VREG_W'(r[2:0]);
    rand_bits(3, r);
    req_vd = VREG_W'(r[2:0]);
    rand_bits(4, r);
    req_use_vs1 = r[0];
    req_use_vs2 = r[1];
    // VCNT has no vector destination
    req_use_vd  = r[2] && (req_op != VCNT);
    req_vm      = r[3];
    rand_bits(VL_W, r);
    req_vl = r[VL_W-1:0];
    rand_bits(SCALAR_W, r);
    req_scalar = r;
    req_valid  = 1'b1;
  endtask

  // Expected RAW, WAR and WAW marks over live ids only
  task automatic predict_hazards();
    exp_vs1 = '0;
    exp_vs2 = '0;
    exp_vd  = '0;
    exp_vm  = '0;
    if (req_use_vs1 && wr_vld[req_vs1])
      exp_vs1[wr_id[req_vs1]] = 1'b1;
    if (req_use_vs2 && wr_vld[req_vs2])
      exp_vs2[wr_id[req_vs2]] = 1'b1;
    if (req_vm && wr_vld[VMASK])
      exp_vm[wr_id[VMASK]] = 1'b1;
    if (req_use_vd && rd_vld[req_vd]) begin
      exp_vs1[rd_id[req_vd]] = 1'b1;
      exp_vs2[rd_id[req_vd]] = 1'b1;
      exp_vm[rd_id[req_vd]]  = 1'b1;
    end
    if (req_use_vd && wr_vld[req_vd])
      exp_vd[wr_id[req_vd]] = 1'b1;
    exp_vs1 &= model_run;
    exp_vs2 &= model_run;
    exp_vd  &= model_run;
    exp_vm  &= model_run;
  endtask

  // Everything here is stable since the last rising edge
  task automatic observe_cycle();
    if (wait_resp) begin
      check_eq(32'(req_ready), 32'd0, "ready low while a response is due");
      if (resp_valid) begin
        if (wait_op == VCNT)
          check_eq(resp_data, 32'(wait_vl), "VCNT element count");
        else
          check_eq(32'(resp_error), 32'(wait_err), "address misalignment flag");
        wait_resp = 1'b0;
      end
    end else begin
      check_eq(32'(resp_valid), 32'd0, "response without a pending request");
    end
    check_eq(32'(issue_valid), 32'(pend_issue), "one issue per accepted request");
    if (issue_valid && pend_issue) begin
      check_eq(32'(pend_busy[issue_id]), 32'd0, "issued id free at acceptance");
      check_eq(32'(hz_vs1), 32'(exp_vs1), "vs1 hazard vector");
      check_eq(32'(hz_vs2), 32'(exp_vs2), "vs2 hazard vector");
      check_eq(32'(hz_vd), 32'(exp_vd), "vd hazard vector");
      check_eq(32'(hz_vm), 32'(exp_vm), "mask hazard vector");
      model_run[issue_id] = 1'b1;
      // Request fields are still held in the issue cycle
      if (req_use_vd) begin
        wr_id[req_vd]  = issue_id;
        wr_vld[req_vd] = 1'b1;
      end
      if (req_use_vs1) begin
        rd_id[req_vs1]  = issue_id;
        rd_vld[req_vs1] = 1'b1;
      end
      if (req_use_vs2) begin
        rd_id[req_vs2]  = issue_id;
        rd_vld[req_vs2] = 1'b1;
      end
      if (req_vm) begin
        rd_id[VMASK]  = issue_id;
        rd_vld[VMASK] = 1'b1;
      end
      pend_issue = 1'b0;
    end
    // Slot still counts as busy in the cycle of its done pulse
    busy_now = model_run;
    for (int i = 0; i < NR_VINSN; i++) begin
      if (done[i]) begin
        check_eq(32'(model_run[i]), 32'd1, "done only for a running id");
        model_run[i] = 1'b0;
        for (int v = 0; v < NR_VREGS; v++) begin
          if (rd_id[v] == VID_W'(i))
            rd_vld[v] = 1'b0;
          if (wr_id[v] == VID_W'(i))
            wr_vld[v] = 1'b0;
        end
      end
    end
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    if (taken) begin
      req_valid = 1'b0;
      taken     = 1'b0;
    end
    if (!req_valid && accepted < NR_REQS) begin
      // About one idle cycle in four
      rand_bits(2, r);
      if (r[1:0] != 2'b00)
        new_request();
    end
    // Accepted on the coming rising edge
    if (req_valid && req_ready) begin
      predict_hazards();
      pend_busy  = busy_now;
      pend_issue = 1'b1;
      taken      = 1'b1;
      accepted++;
      if (req_op inside {VLE, VSE, VCNT}) begin
        wait_resp = 1'b1;
        wait_op   = req_op;
        wait_vl   = req_vl;
        wait_err  = |req_scalar[1:0];
      end
    end
  endtask

  // Watchdog
  initial cycles = 0;
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display(">>> FAIL");
      $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  initial begin
    lfsr_q      = 32'hf591;
    req_valid   = 1'b0;
    req_op      = VADD;
    req_vs1     = '0;
    req_vs2     = '0;
    req_vd      = '0;
    req_use_vs1 = 1'b0;
    req_use_vs2 = 1'b0;
    req_use_vd  = 1'b0;
    req_vm      = 1'b0;
    req_vl      = '0;
    req_scalar  = '0;
    model_run   = '0;
    busy_now    = '0;
    rd_vld      = '0;
    wr_vld      = '0;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_id[v] = '0;
      wr_id[v] = '0;
    end
    pend_issue = 1'b0;
    taken      = 1'b0;
    wait_resp  = 1'b0;
    accepted   = 0;
    @(posedge rst_n);
    @(negedge clk);
    check_eq(32'(req_ready), 32'd1, "ready after reset");
    check_eq(32'(done), 32'd0, "done after reset");
    check_eq(32'(issue_valid), 32'd0, "issue pulse after reset");
    while (accepted < NR_REQS) begin
      observe_cycle();
      drive_cycle();
      @(negedge clk);
    end
    // Drain until every issued id has retired
    req_valid = 1'b0;
    while (model_run != '0 || pend_issue || wait_resp) begin
      observe_cycle();
      @(negedge clk);
    end
    check_eq(32'(done), 32'd0, "done after the drain");
    check_eq(32'(req_ready), 32'd1, "ready after the drain");
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- tb_clkgen.sv
//****************************************
// Testbench clock and reset generator
//****************************************
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns clock period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for four cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- vseq_top.sv
//****************************************
// Vector sequencer subsystem top
//****************************************
`timescale 1ns/10ps

module vseq_top import vseq_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatcher
  input  logic                req_valid_i,
  input  vseq_op_e            req_op_i,
  input  logic [VREG_W-1:0]   req_vs1_i,
  input  logic                req_use_vs1_i,
  input  logic [VREG_W-1:0]   req_vs2_i,
  input  logic                req_use_vs2_i,
  input  logic [VREG_W-1:0]   req_vd_i,
  input  logic                req_use_vd_i,
  input  logic                req_vm_i,
  input  logic [VL_W-1:0]     req_vl_i,
  input  logic [SCALAR_W-1:0] req_scalar_i,
  output logic                req_ready_o,
  // Response and completions
  output logic                resp_valid_o,
  output logic [SCALAR_W-1:0] resp_data_o,
  output logic                resp_error_o,
  output logic [NR_VINSN-1:0] done_o,
  // Issue trace
  output logic                issue_valid_o,
  output logic [VID_W-1:0]    issue_id_o,
  output logic [NR_VINSN-1:0] issue_hazard_vs1_o,
  output logic [NR_VINSN-1:0] issue_hazard_vs2_o,
  output logic [NR_VINSN-1:0] issue_hazard_vd_o,
  output logic [NR_VINSN-1:0] issue_hazard_vm_o
);

  // Issue bus
  logic                pe_req_valid;
  logic [VID_W-1:0]    pe_id;
  vseq_op_e            pe_op;
  vseq_vfu_e           pe_vfu;
  logic [VL_W-1:0]     pe_vl;
  logic [SCALAR_W-1:0] pe_scalar;
  logic [NR_VINSN-1:0] pe_hazard_vs1, pe_hazard_vs2, pe_hazard_vd, pe_hazard_vm;

  // PE feedback, memory unit is the last PE
  logic [NR_PES-1:0]                   pe_ready;
  logic [NR_PES-1:0][NR_VINSN-1:0]     pe_done;
  logic                                addrgen_ack, addrgen_error;
  logic [NR_LANES-1:0]                 lane_scalar_valid;
  logic [NR_LANES-1:0][SCALAR_W-1:0]   lane_scalar_result;

  always_comb begin
    done_o = '0;
    for (int p = 0; p < NR_PES; p++)
      done_o |= pe_done[p];
  end

  assign issue_valid_o      = pe_req_valid;
  assign issue_id_o         = pe_id;
  assign issue_hazard_vs1_o = pe_hazard_vs1;
  assign issue_hazard_vs2_o = pe_hazard_vs2;
  assign issue_hazard_vd_o  = pe_hazard_vd;
  assign issue_hazard_vm_o  = pe_hazard_vm;

  vseq_sequencer u_sequencer (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vs1_i, .req_use_vs1_i, .req_vs2_i, .req_use_vs2_i,
    .req_vd_i, .req_use_vd_i, .req_vm_i, .req_vl_i, .req_scalar_i, .req_ready_o,
    .pe_ready_i      (pe_ready),
    .pe_done_i       (pe_done),
    .addrgen_ack_i   (addrgen_ack),
    .addrgen_error_i (addrgen_error),
    // Only lane 0 answers scalar requests
    .scalar_valid_i  (lane_scalar_valid[0]),
    .scalar_result_i (lane_scalar_result[0]),
    .resp_valid_o, .resp_data_o, .resp_error_o,
    .pe_req_valid_o  (pe_req_valid),
    .pe_id_o         (pe_id),
    .pe_op_o         (pe_op),
    .pe_vfu_o        (pe_vfu),
    .pe_vl_o         (pe_vl),
    .pe_scalar_o     (pe_scalar),
    .pe_hazard_vs1_o (pe_hazard_vs1),
    .pe_hazard_vs2_o (pe_hazard_vs2),
    .pe_hazard_vd_o  (pe_hazard_vd),
    .pe_hazard_vm_o  (pe_hazard_vm)
  );

  for (genvar g = 0; g < NR_LANES; g++) begin : g_lane
    vseq_lane u_lane (
      .clk_i, .rst_ni,
      .pe_req_valid_i  (pe_req_valid),
      .pe_id_i         (pe_id),
      .pe_op_i         (pe_op),
      .pe_vfu_i        (pe_vfu),
      .pe_vl_i         (pe_vl),
      .pe_hazard_vs1_i (pe_hazard_vs1),
      .pe_hazard_vs2_i (pe_hazard_vs2),
      .pe_hazard_vd_i  (pe_hazard_vd),
      .pe_hazard_vm_i  (pe_hazard_vm),
      .done_all_i      (done_o),
      .ready_o         (pe_ready[g]),
      .done_o          (pe_done[g]),
      .scalar_valid_o  (lane_scalar_valid[g]),
      .scalar_result_o (lane_scalar_result[g])
    );
  end

  vseq_mem_unit u_mem_unit (
    .clk_i, .rst_ni,
    .pe_req_valid_i  (pe_req_valid),
    .pe_id_i         (pe_id),
    .pe_vfu_i        (pe_vfu),
    .pe_vl_i         (pe_vl),
    .pe_scalar_i     (pe_scalar),
    .pe_hazard_vs1_i (pe_hazard_vs1),
    .pe_hazard_vs2_i (pe_hazard_vs2),
    .pe_hazard_vd_i  (pe_hazard_vd),
    .pe_hazard_vm_i  (pe_hazard_vm),
    .done_all_i      (done_o),
    .ready_o         (pe_ready[NR_LANES]),
    .done_o          (pe_done[NR_LANES]),
    .addrgen_ack_o   (addrgen_ack),
    .addrgen_error_o (addrgen_error)
  );

endmodule

//--- vseq_mem_unit.sv
//****************************************
// Load/store unit occupancy model
// Address acknowledge, then element transfer
//****************************************
`timescale 1ns/10ps

module vseq_mem_unit import vseq_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Issue bus
  input  logic                pe_req_valid_i,
  input  logic [VID_W-1:0]    pe_id_i,
  input  vseq_vfu_e           pe_vfu_i,
  input  logic [VL_W-1:0]     pe_vl_i,
  input  logic [SCALAR_W-1:0] pe_scalar_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vs1_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vs2_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vd_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vm_i,
  // Completions of all PEs
  input  logic [NR_VINSN-1:0] done_all_i,
  output logic                ready_o,
  output logic [NR_VINSN-1:0] done_o,
  output logic                addrgen_ack_o,
  output logic                addrgen_error_o
);

  typedef enum logic [1:0] { M_IDLE, M_ADDR, M_HAZ, M_RUN } mem_state_e;

  mem_state_e          state_q;
  logic                issue_me, take;
  logic [VID_W-1:0]    id_q;
  logic [VL_W-1:0]     vl_q, cnt_q;
  logic                misalign_q;
  logic [NR_VINSN-1:0] haz_q, haz_left;

  assign issue_me = pe_req_valid_i && (pe_vfu_i == VFU_MEM);
  assign take     = issue_me && (state_q == M_IDLE);
  assign ready_o  = (state_q == M_IDLE) && !issue_me;
  assign haz_left = haz_q & ~done_all_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= M_IDLE;
      cnt_q           <= '0;
      haz_q           <= '0;
      done_o          <= '0;
      addrgen_ack_o   <= 1'b0;
      addrgen_error_o <= 1'b0;
    end else begin
      done_o          <= '0;
      addrgen_ack_o   <= 1'b0;
      addrgen_error_o <= 1'b0;
      // Hazards keep clearing during address generation
      haz_q           <= haz_left;
      case (state_q)
        M_IDLE: begin
          if (take) begin
            haz_q   <= (pe_hazard_vs1_i | pe_hazard_vs2_i | pe_hazard_vd_i |
                        pe_hazard_vm_i) & ~done_all_i;
            cnt_q   <= VL_W'(ADDRGEN_LAT - 1);
            state_q <= M_ADDR;
          end
        end
        M_ADDR: begin
          cnt_q <= cnt_q - VL_W'(1);
          if (cnt_q == VL_W'(1)) begin
            addrgen_ack_o   <= 1'b1;
            addrgen_error_o <= misalign_q;
            // Misaligned accesses still run to completion
            cnt_q           <= (vl_q == '0) ? VL_W'(1) : vl_q;
            state_q         <= M_HAZ;
          end
        end
        M_HAZ: begin
          if (haz_left == '0)
            state_q <= M_RUN;
        end
        M_RUN: begin
          cnt_q <= cnt_q - VL_W'(1);
          if (cnt_q == VL_W'(1)) begin
            done_o[id_q] <= 1'b1;
            state_q      <= M_IDLE;
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // Instruction payload and word alignment check
  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q       <= pe_id_i;
      vl_q       <= pe_vl_i;
      misalign_q <= |pe_scalar_i[1:0];
    end
  end

  // Acknowledge comes ADDRGEN_LAT cycles after the issue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    addrgen_ack_o |-> $past(take, ADDRGEN_LAT));

endmodule

//--- vseq_lane.sv
//****************************************
// Arithmetic lane occupancy model
//****************************************
`timescale 1ns/10ps

module vseq_lane import vseq_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Issue bus
  input  logic                pe_req_valid_i,
  input  logic [VID_W-1:0]    pe_id_i,
  input  vseq_op_e            pe_op_i,
  input  vseq_vfu_e           pe_vfu_i,
  input  logic [VL_W-1:0]     pe_vl_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vs1_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vs2_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vd_i,
  input  logic [NR_VINSN-1:0] pe_hazard_vm_i,
  // Completions of all PEs
  input  logic [NR_VINSN-1:0] done_all_i,
  output logic                ready_o,
  output logic [NR_VINSN-1:0] done_o,
  output logic                scalar_valid_o,
  output logic [SCALAR_W-1:0] scalar_result_o
);

  typedef enum logic [1:0] { L_IDLE, L_HAZ, L_RUN } lane_state_e;

  lane_state_e         state_q;
  logic                issue_me, take;
  logic [VID_W-1:0]    id_q;
  logic                is_cnt_q;
  logic [VL_W-1:0]     vl_q, cnt_q, share;
  logic [NR_VINSN-1:0] haz_q, haz_left;

  assign issue_me = pe_req_valid_i && (pe_vfu_i == VFU_ALU);
  assign take     = issue_me && (state_q == L_IDLE);
  // Drops in the issue cycle too, before the state shows busy
  assign ready_o  = (state_q == L_IDLE) && !issue_me;

  // Element share of this lane, rounded up
  assign share = pe_vl_i / VL_W'(NR_LANES) +
                 VL_W'((pe_vl_i % VL_W'(NR_LANES)) != '0);

  assign haz_left = haz_q & ~done_all_i;

  // Element count as the scalar answer
  assign scalar_result_o = SCALAR_W'(vl_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= L_IDLE;
      cnt_q          <= '0;
      haz_q          <= '0;
      done_o         <= '0;
      scalar_valid_o <= 1'b0;
    end else begin
      done_o         <= '0;
      scalar_valid_o <= 1'b0;
      haz_q          <= haz_left;
      case (state_q)
        L_IDLE: begin
          if (take) begin
            // Ids done right now no longer block
            haz_q   <= (pe_hazard_vs1_i | pe_hazard_vs2_i | pe_hazard_vd_i |
                        pe_hazard_vm_i) & ~done_all_i;
            cnt_q   <= (share == '0) ? VL_W'(1) : share;
            state_q <= L_HAZ;
          end
        end
        L_HAZ: begin
          if (haz_left == '0)
            state_q <= L_RUN;
        end
        L_RUN: begin
          cnt_q <= cnt_q - VL_W'(1);
          if (cnt_q == VL_W'(1)) begin
            done_o[id_q]   <= 1'b1;
            scalar_valid_o <= is_cnt_q;
            state_q        <= L_IDLE;
          end
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q     <= pe_id_i;
      vl_q     <= pe_vl_i;
      is_cnt_q <= (pe_op_i == VCNT);
    end
  end

  // Sequencer back-pressure keeps the lane single-occupied
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_me |-> state_q == L_IDLE);

endmodule

//--- vseq_sequencer.sv
//****************************************
// Vector sequencer
// Allocates ids, tracks hazards, issues to the PEs
//****************************************
`timescale 1ns/10ps

module vseq_sequencer import vseq_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Dispatcher request
  input  logic                            req_valid_i,
  input  vseq_op_e                        req_op_i,
  input  logic [VREG_W-1:0]               req_vs1_i,
  input  logic                            req_use_vs1_i,
  input  logic [VREG_W-1:0]               req_vs2_i,
  input  logic                            req_use_vs2_i,
  input  logic [VREG_W-1:0]               req_vd_i,
  input  logic                            req_use_vd_i,
  input  logic                            req_vm_i,
  input  logic [VL_W-1:0]                 req_vl_i,
  input  logic [SCALAR_W-1:0]             req_scalar_i,
  output logic                            req_ready_o,
  // Feedback from the processing elements
  input  logic [NR_PES-1:0]               pe_ready_i,
  input  logic [NR_PES-1:0][NR_VINSN-1:0] pe_done_i,
  input  logic                            addrgen_ack_i,
  input  logic                            addrgen_error_i,
  input  logic                            scalar_valid_i,
  input  logic [SCALAR_W-1:0]             scalar_result_i,
  // Response to the dispatcher
  output logic                            resp_valid_o,
  output logic [SCALAR_W-1:0]             resp_data_o,
  output logic                            resp_error_o,
  // Issue bus
  output logic                            pe_req_valid_o,
  output logic [VID_W-1:0]                pe_id_o,
  output vseq_op_e                        pe_op_o,
  output vseq_vfu_e                       pe_vfu_o,
  output logic [VL_W-1:0]                 pe_vl_o,
  output logic [SCALAR_W-1:0]             pe_scalar_o,
  output logic [NR_VINSN-1:0]             pe_hazard_vs1_o,
  output logic [NR_VINSN-1:0]             pe_hazard_vs2_o,
  output logic [NR_VINSN-1:0]             pe_hazard_vd_o,
  output logic [NR_VINSN-1:0]             pe_hazard_vm_o
);

  typedef enum logic { IDLE, WAIT } state_e;

  state_e state_d, state_q;

  // Slot occupancy per PE
  logic [NR_PES-1:0][NR_VINSN-1:0] pe_run_d, pe_run_q;
  logic [NR_VINSN-1:0] running;
  // Running set without the ids that finish this cycle
  logic [NR_VINSN-1:0] alive;
  logic [VID_W-1:0]    next_id;
  logic                full;
  logic                accept;
  vseq_vfu_e           req_vfu;

  // Last reader and last writer of each register
  logic [NR_VREGS-1:0]            rd_vld_d, rd_vld_q, wr_vld_d, wr_vld_q;
  logic [NR_VREGS-1:0][VID_W-1:0] rd_id_d, rd_id_q, wr_id_d, wr_id_q;

  logic [NR_VINSN-1:0] haz_vs1, haz_vs2, haz_vd, haz_vm;

  always_comb begin
    running = '0;
    alive   = '0;
    for (int p = 0; p < NR_PES; p++) begin
      running |= pe_run_q[p];
      alive   |= pe_run_q[p] & ~pe_done_i[p];
    end
  end

  // Lowest free slot gives the next id
  always_comb begin
    next_id = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running[i])
        next_id = VID_W'(i);
    end
  end

  assign full    = &running;
  assign req_vfu = op_vfu(req_op_i);
  // Busy PEs, full slots and a pending response stall the dispatcher
  assign req_ready_o = (state_q == IDLE) && (&pe_ready_i) && !full;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    state_d      = state_q;
    resp_valid_o = 1'b0;
    resp_data_o  = '0;
    resp_error_o = 1'b0;
    // Retire finished ids
    pe_run_d = pe_run_q & ~pe_done_i;
    rd_id_d  = rd_id_q;
    wr_id_d  = wr_id_q;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_vld_d[v] = rd_vld_q[v] & alive[rd_id_q[v]];
      wr_vld_d[v] = wr_vld_q[v] & alive[wr_id_q[v]];
    end
    haz_vs1 = '0;
    haz_vs2 = '0;
    haz_vd  = '0;
    haz_vm  = '0;

    case (state_q)
      IDLE: begin
        if (accept) begin
          // Occupy the slot on every PE of the target unit
          if (req_vfu == VFU_MEM) begin
            pe_run_d[NR_LANES][next_id] = 1'b1;
          end else begin
            for (int l = 0; l < NR_LANES; l++)
              pe_run_d[l][next_id] = 1'b1;
          end
          // RAW on sources from live writers
          if (req_use_vs1_i && wr_vld_d[req_vs1_i])
            haz_vs1[wr_id_d[req_vs1_i]] = 1'b1;
          if (req_use_vs2_i && wr_vld_d[req_vs2_i])
            haz_vs2[wr_id_d[req_vs2_i]] = 1'b1;
          if (req_vm_i && wr_vld_d[VMASK])
            haz_vm[wr_id_d[VMASK]] = 1'b1;
          // WAR marks every source vector
          if (req_use_vd_i && rd_vld_d[req_vd_i]) begin
            haz_vs1[rd_id_d[req_vd_i]] = 1'b1;
            haz_vs2[rd_id_d[req_vd_i]] = 1'b1;
            haz_vm[rd_id_d[req_vd_i]]  = 1'b1;
          end
          // WAW
          if (req_use_vd_i && wr_vld_d[req_vd_i])
            haz_vd[wr_id_d[req_vd_i]] = 1'b1;
          // New owner of the accessed registers
          if (req_use_vd_i) begin
            wr_id_d[req_vd_i]  = next_id;
            wr_vld_d[req_vd_i] = 1'b1;
          end
          if (req_use_vs1_i) begin
            rd_id_d[req_vs1_i]  = next_id;
            rd_vld_d[req_vs1_i] = 1'b1;
          end
          if (req_use_vs2_i) begin
            rd_id_d[req_vs2_i]  = next_id;
            rd_vld_d[req_vs2_i] = 1'b1;
          end
          if (req_vm_i) begin
            rd_id_d[VMASK]  = next_id;
            rd_vld_d[VMASK] = 1'b1;
          end
          // Loads, stores and VCNT answer the dispatcher
          if (req_op_i inside {VLE, VSE, VCNT})
            state_d = WAIT;
        end
      end
      WAIT: begin
        // Held issue bus tells which answer is expected
        if (pe_vfu_o == VFU_MEM) begin
          if (addrgen_ack_i) begin
            resp_valid_o = 1'b1;
            resp_error_o = addrgen_error_i;
            state_d      = IDLE;
          end
        end else if (scalar_valid_i) begin
          resp_valid_o = 1'b1;
          resp_data_o  = scalar_result_i;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= IDLE;
      pe_run_q        <= '0;
      rd_vld_q        <= '0;
      wr_vld_q        <= '0;
      rd_id_q         <= '0;
      wr_id_q         <= '0;
      pe_req_valid_o  <= 1'b0;
      pe_id_o         <= '0;
      pe_op_o         <= VADD;
      pe_vfu_o        <= VFU_ALU;
      pe_vl_o         <= '0;
      pe_scalar_o     <= '0;
      pe_hazard_vs1_o <= '0;
      pe_hazard_vs2_o <= '0;
      pe_hazard_vd_o  <= '0;
      pe_hazard_vm_o  <= '0;
    end else begin
      state_q        <= state_d;
      pe_run_q       <= pe_run_d;
      rd_vld_q       <= rd_vld_d;
      wr_vld_q       <= wr_vld_d;
      rd_id_q        <= rd_id_d;
      wr_id_q        <= wr_id_d;
      pe_req_valid_o <= accept;
      // Issue fields hold until the next acceptance
      if (accept) begin
        pe_id_o         <= next_id;
        pe_op_o         <= req_op_i;
        pe_vfu_o        <= req_vfu;
        pe_vl_o         <= req_vl_i;
        pe_scalar_o     <= req_scalar_i;
        pe_hazard_vs1_o <= haz_vs1;
        pe_hazard_vs2_o <= haz_vs2;
        pe_hazard_vd_o  <= haz_vd;
        pe_hazard_vm_o  <= haz_vm;
      end
    end
  end

  // Slots must not be overbooked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> !running[next_id]);

  // Answers from the PEs arrive only while a response is awaited
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (addrgen_ack_i || scalar_valid_i) |-> (state_q == WAIT));

endmodule

//--- vseq_pkg.sv
//****************************************
// Vector sequencer shared definitions
// Sizes, opcodes and unit selection
//****************************************
package vseq_pkg;

  // Processing elements
  localparam int unsigned NR_LANES = 2;
  // Lanes plus the memory unit
  localparam int unsigned NR_PES   = NR_LANES + 1;

  // Instruction slots
  localparam int unsigned NR_VINSN = 4;
  localparam int unsigned VID_W    = 2;

  // Vector register file
  localparam int unsigned NR_VREGS = 32;
  localparam int unsigned VREG_W   = 5;
  localparam logic [VREG_W-1:0] VMASK = '0;

  // Operand widths
  localparam int unsigned VL_W     = 6;
  localparam int unsigned SCALAR_W = 32;

  // Address generation latency in cycles after the issue
  localparam int unsigned ADDRGEN_LAT = 2;

  // Opcodes, VCNT returns a scalar and writes no vd
  typedef enum logic [2:0] {
    VADD, VSUB, VAND, VOR, VXOR, VLE, VSE, VCNT
  } vseq_op_e;

  // Target unit of an instruction
  typedef enum logic {
    VFU_ALU,
    VFU_MEM
  } vseq_vfu_e;

  // Loads and stores go to the memory unit, the rest to the lanes
  function automatic vseq_vfu_e op_vfu(vseq_op_e op);
    return (op == VLE || op == VSE) ? VFU_MEM : VFU_ALU;
  endfunction

endpackage
